/* src.f */
+incdir+rtl
rtl/hexlcd_pkg.sv
rtl/eink_bus_probe.sv
rtl/hex_pixel_render.sv
rtl/lcd_spi_writer.sv
rtl/eink_status_lcd_top.sv
test/tb_lcd_spi_decoder.sv
test/tb_eink_status_lcd.sv

/* Bender.yml */
package:
  name: eink_status_lcd

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/hexlcd_pkg.sv
      - rtl/eink_bus_probe.sv
      - rtl/hex_pixel_render.sv
      - rtl/lcd_spi_writer.sv
      - rtl/eink_status_lcd_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_lcd_spi_decoder.sv
      - test/tb_eink_status_lcd.sv

/* test/tb_eink_status_lcd.sv */
`timescale 1ns/1ns
`include "hexlcd_settings.svh"

module tb_eink_status_lcd;
    import hexlcd_pkg::*;

    localparam int T_RELAY     = 0;
    localparam int T_INIT      = 1;
    localparam int T_FRAME     = 2;
    localparam int T_IDLE      = 3;
    localparam int T_SNOOP     = 4;
    localparam int NPIX        = `HEXLCD_WIDTH * `HEXLCD_HEIGHT;
    localparam int FRAME_LIMIT = 60000;   // one frame is roughly 49k clocks
    localparam int HOST_HALF   = 4;       // slow host spi half period
    localparam int SNOOP_BYTES = 9;

    typedef struct packed {
        logic dc;
        logic sdi;
        logic cs;
        logic clk;
        logic busy;
    } eink_pins_t;

    logic         clk;
    logic         rst_n;
    logic         host_dc;
    logic         host_sdi;
    logic         host_cs;
    logic         host_clk;
    logic         host_busy;
    logic         panel_dc;
    logic         panel_sdi;
    logic         panel_cs;
    logic         panel_clk;
    logic         panel_busy;
    logic         spi_clk;
    logic         spi_mosi;
    logic         spi_dc;
    logic         spi_csn;
    logic         spi_resn;
    logic [7:0]   dec_byte;
    logic         dec_dc;
    logic [31:0]  dec_seq;

    eink_pins_t   relay_in;               // host side pins seen at the last edge
    logic         relay_armed = 1'b0;
    logic [31:0]  seen_seq = 0;
    int           init_got = 0;
    logic         in_frame = 1'b0;
    int           data_bytes = 0;
    logic [7:0]   hi_byte;
    int           frame_starts = 0;
    int           frames_done = 0;
    logic         checking = 1'b0;        // current frame compared pixel by pixel
    int           check_frame;
    int           pix_test;
    status_word_t exp_word;
    int           seed;
    logic         abort = 1'b0;
    int           errs [5];
    int           checks = 0;
    int           failed;
    int           t;
    string        test_name [5] = '{"relay", "init", "framing", "idle display", "snoop"};

    eink_status_lcd_top u_eink_status_lcd_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_dc    (host_dc),
        .host_sdi   (host_sdi),
        .host_cs    (host_cs),
        .host_clk   (host_clk),
        .host_busy  (host_busy),
        .panel_dc   (panel_dc),
        .panel_sdi  (panel_sdi),
        .panel_cs   (panel_cs),
        .panel_clk  (panel_clk),
        .panel_busy (panel_busy),
        .spi_clk    (spi_clk),
        .spi_mosi   (spi_mosi),
        .spi_dc     (spi_dc),
        .spi_csn    (spi_csn),
        .spi_resn   (spi_resn)
    );

    tb_lcd_spi_decoder u_decoder (
        .spi_clk   (spi_clk),
        .spi_mosi  (spi_mosi),
        .spi_dc    (spi_dc),
        .spi_csn   (spi_csn),
        .byte_data (dec_byte),
        .byte_dc   (dec_dc),
        .byte_seq  (dec_seq)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;            // 4 ns period
    end

    task automatic expect_equal(input int test, input string name,
                                input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errs[test]++;
            $display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic note_problem(input int test, input string msg);
        errs[test]++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // colour of pixel idx, from the digit layout and the font
    function automatic logic [15:0] expected_colour(input status_word_t word, input int idx);
        int         px;
        int         py;
        int         dig;
        logic [3:0] nib;
        logic [5:0] row;
        px  = idx % `HEXLCD_WIDTH;
        py  = idx / `HEXLCD_WIDTH;
        dig = (py / `HEXLCD_GLYPH_H) * `HEXLCD_COLS + px / `HEXLCD_GLYPH_W;
        nib = word[63 - 4 * dig -: 4];                  // digit 0 is the top nibble
        row = hex_font[nib][py % `HEXLCD_GLYPH_H];
        expected_colour = row[`HEXLCD_GLYPH_W - 1 - px % `HEXLCD_GLYPH_W] ?
                          `HEXLCD_FG : `HEXLCD_BG;
    endfunction

    // relay pins, captured at the edge and checked half a cycle later
    always @(posedge clk)
    begin
        relay_in    <= '{host_dc, host_sdi, host_cs, host_clk, panel_busy};
        relay_armed <= rst_n;
    end

    always @(negedge clk)
    begin
        if (rst_n && relay_armed)
        begin
            expect_equal(T_RELAY, "panel_dc", panel_dc, relay_in.dc);
            expect_equal(T_RELAY, "panel_sdi", panel_sdi, relay_in.sdi);
            expect_equal(T_RELAY, "panel_cs", panel_cs, relay_in.cs);
            expect_equal(T_RELAY, "panel_clk", panel_clk, relay_in.clk);
            expect_equal(T_RELAY, "host_busy", host_busy, relay_in.busy);
        end
    end

    task automatic take_lcd_byte(input logic [7:0] b, input logic dc);
        if (spi_resn !== 1'b1)
            note_problem(T_INIT, "lcd byte sent while the panel was still in reset");
        else if (init_got < LCD_INIT_LEN)
        begin
            expect_equal(T_INIT, "init byte", b, lcd_init_bytes[init_got].data);
            expect_equal(T_INIT, "init spi_dc", dc, lcd_init_bytes[init_got].dc);
            init_got++;
        end
        else if (!in_frame)
        begin
            expect_equal(T_FRAME, "frame command", b, LCD_RAMWR);
            expect_equal(T_FRAME, "command spi_dc", dc, 1'b0);
            in_frame   = 1'b1;
            data_bytes = 0;
            checking   = (frame_starts == check_frame);
            frame_starts++;
        end
        else
        begin
            expect_equal(T_FRAME, "pixel spi_dc", dc, 1'b1);
            if (data_bytes % 2 == 0)
                hi_byte = b;                              // high colour byte first
            else if (checking)
                expect_equal(pix_test, "pixel colour", {hi_byte, b},
                             expected_colour(exp_word, data_bytes / 2));
            data_bytes++;
        end
    endtask

    // byte stream and frame ends, read away from the lcd's edges
    always @(negedge clk)
    begin
        if (dec_seq != seen_seq)
        begin
            seen_seq = dec_seq;
            take_lcd_byte(dec_byte, dec_dc);
        end
        if (in_frame && spi_csn === 1'b1)
        begin
            expect_equal(T_FRAME, "frame data byte count", data_bytes, 2 * NPIX);
            in_frame = 1'b0;
            frames_done++;
        end
    end

    task automatic drive_relay_pattern();
        int i;
        for (i = 0; i < 24; i++)
        begin
            @(negedge clk);
            host_dc    = 1'($random(seed));
            host_sdi   = 1'($random(seed));
            host_clk   = 1'($random(seed));     // cs high, nothing snooped
            panel_busy = 1'($random(seed));
        end
        @(negedge clk);
        host_clk = 1'b0;
        for (i = 0; i < 6; i++)
        begin
            @(negedge clk);
            host_cs = 1'($random(seed));        // clock parked low
        end
        @(negedge clk);
        host_cs    = 1'b1;
        host_dc    = 1'b0;
        host_sdi   = 1'b0;
        panel_busy = 1'b0;
    endtask

    task automatic send_host_byte(input logic [7:0] b);
        int i;
        for (i = 7; i >= 0; i--)
        begin
            host_sdi = b[i];                    // mode 0, msb first
            repeat (HOST_HALF) @(negedge clk);
            host_clk = 1'b1;
            repeat (HOST_HALF) @(negedge clk);
            host_clk = 1'b0;
        end
    endtask

    task automatic run_snoop();
        status_word_t w;
        logic [7:0]   b;
        int           i;
        w = '0;
        @(negedge clk);
        panel_busy = 1'b1;
        host_dc    = 1'b1;                      // data phase on the e-ink bus
        host_cs    = 1'b0;
        repeat (HOST_HALF) @(negedge clk);
        for (i = 0; i < SNOOP_BYTES; i++)
        begin
            b = 8'($random(seed));
            send_host_byte(b);
            w.last_bytes = {w.last_bytes[39:0], b};
        end
        repeat (HOST_HALF) @(negedge clk);
        host_cs      = 1'b1;
        w.busy       = 1'b1;
        w.dc         = 1'b1;
        w.byte_count = 14'(SNOOP_BYTES);
        @(posedge clk);
        if (frame_starts != 2)
            note_problem(T_SNOOP, "host burst did not fit inside one lcd frame");
        exp_word    = w;
        pix_test    = T_SNOOP;
        check_frame = frame_starts;             // the frame after this one
    endtask

    task automatic wait_init();
        int n;
        n = 0;
        while (init_got < LCD_INIT_LEN && n < 2000)
        begin
            @(posedge clk);
            n++;
        end
        if (init_got < LCD_INIT_LEN)
        begin
            abort = 1'b1;
            $display("timeout: lcd init sequence incomplete after %0d clocks", n);
        end
    endtask

    task automatic wait_frames_done(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (frames_done < target && n < limit)
        begin
            @(posedge clk);
            n++;
        end
        if (frames_done < target)
        begin
            abort = 1'b1;
            $display("timeout: %s did not finish within %0d clocks", what, limit);
        end
    endtask

    task automatic wait_frame_start(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (frame_starts < target && n < limit)
        begin
            @(posedge clk);
            n++;
        end
        if (frame_starts < target)
        begin
            abort = 1'b1;
            $display("timeout: %s never started", what);
        end
    endtask

    task automatic report_test(input int tn);
        $display("test %s: %s, %0d errors", test_name[tn], (errs[tn] == 0) ? "ok" : "bad",
                 errs[tn]);
    endtask

    initial
    begin
        seed        = 39;
        rst_n       = 1'b0;
        host_dc     = 1'b0;
        host_sdi    = 1'b0;
        host_cs     = 1'b1;
        host_clk    = 1'b0;                     // mode 0 idle
        panel_busy  = 1'b0;
        exp_word    = '0;                       // blank status on the first frame
        check_frame = 0;
        pix_test    = T_IDLE;
        for (t = 0; t < 5; t++)
            errs[t] = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        drive_relay_pattern();
        wait_init();
        if (!abort)
        begin
            report_test(T_INIT);
            wait_frames_done(1, FRAME_LIMIT, "first lcd frame");
        end
        if (!abort)
        begin
            report_test(T_IDLE);
            wait_frame_start(2, 400, "second lcd frame");
        end
        if (!abort)
        begin
            run_snoop();
            wait_frames_done(3, 2 * FRAME_LIMIT, "frame after the host burst");
        end
        if (!abort)
            report_test(T_SNOOP);
        report_test(T_FRAME);
        report_test(T_RELAY);
        failed = 0;
        for (t = 0; t < 5; t++)
            if (errs[t] != 0)
                failed++;
        $display("summary: 5 tests, %0d passed, %0d failed, %0d checks", 5 - failed, failed,
                 checks);
        if (abort || failed != 0)
            $display("TESTS FAILED");
        else
            $display("TESTS PASSED");
        $finish;
    end

endmodule

/* test/tb_lcd_spi_decoder.sv */
`timescale 1ns/1ns

module tb_lcd_spi_decoder (
    input  logic        spi_clk,
    input  logic        spi_mosi,
    input  logic        spi_dc,
    input  logic        spi_csn,
    output logic [7:0]  byte_data,   // last complete byte
    output logic        byte_dc,     // dc seen with its last bit
    output logic [31:0] byte_seq     // bumps once per byte
);
    logic [7:0] shift_q;
    int         bits;

    initial
    begin
        shift_q   = 8'h00;
        bits      = 0;
        byte_data = 8'h00;
        byte_dc   = 1'b0;
        byte_seq  = 0;
    end

    // mode 3, panel side view: sample on the rising edge, msb first
    always @(posedge spi_clk or posedge spi_csn)
    begin
        if (spi_csn !== 1'b0)
            bits = 0;                          // deselect drops a partial byte
        else
        begin
            shift_q = {shift_q[6:0], spi_mosi};
            bits    = bits + 1;
            if (bits == 8)
            begin
                bits      = 0;
                byte_data = shift_q;
                byte_dc   = spi_dc;            // dc stable across the byte
                byte_seq  = byte_seq + 1;
            end
        end
    end

endmodule

/* rtl/eink_status_lcd_top.sv */
`timescale 1ns/1ns

module eink_status_lcd_top (
    input  logic clk,
    input  logic rst_n,
    input  logic host_dc,     // from the esp32
    input  logic host_sdi,
    input  logic host_cs,
    input  logic host_clk,
    output logic host_busy,
    output logic panel_dc,    // to the e-ink panel
    output logic panel_sdi,
    output logic panel_cs,
    output logic panel_clk,
    input  logic panel_busy,
    output logic spi_clk,     // to the colour lcd
    output logic spi_mosi,
    output logic spi_dc,
    output logic spi_csn,
    output logic spi_resn
);
    import hexlcd_pkg::*;

    status_word_t status;
    logic         status_valid;
    logic         status_ready;
    pixel_t       pixel;
    logic         pixel_valid;
    logic         pixel_ready;

    eink_bus_probe u_eink_bus_probe (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_dc      (host_dc),
        .host_sdi     (host_sdi),
        .host_cs      (host_cs),
        .host_clk     (host_clk),
        .panel_busy   (panel_busy),
        .status_ready (status_ready),
        .panel_dc     (panel_dc),
        .panel_sdi    (panel_sdi),
        .panel_cs     (panel_cs),
        .panel_clk    (panel_clk),
        .host_busy    (host_busy),
        .status_valid (status_valid),
        .status       (status)
    );

    hex_pixel_render u_hex_pixel_render (
        .clk          (clk),
        .rst_n        (rst_n),
        .status_valid (status_valid),
        .status       (status),
        .pixel_ready  (pixel_ready),
        .status_ready (status_ready),
        .pixel_valid  (pixel_valid),
        .pixel        (pixel)
    );

    lcd_spi_writer u_lcd_spi_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .pixel_ready (pixel_ready),
        .spi_clk     (spi_clk),
        .spi_mosi    (spi_mosi),
        .spi_dc      (spi_dc),
        .spi_csn     (spi_csn),
        .spi_resn    (spi_resn)
    );

endmodule

/* rtl/lcd_spi_writer.sv */
`timescale 1ns/1ns
`include "hexlcd_settings.svh"

module lcd_spi_writer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pixel_valid,
    input  hexlcd_pkg::pixel_t pixel,
    output logic               pixel_ready,
    output logic               spi_clk,
    output logic               spi_mosi,
    output logic               spi_dc,
    output logic               spi_csn,
    output logic               spi_resn
);
    import hexlcd_pkg::*;

    localparam int DIV  = `HEXLCD_SPI_DIV;
    localparam int HOLD = `HEXLCD_RESET_HOLD;

    typedef enum logic [2:0] {
        S_RESET,   // lcd reset pulse
        S_INIT,    // init list
        S_IDLE,    // between frames, csn high
        S_CMD,     // ramwr
        S_HI,      // colour high byte, takes the pixel
        S_LO,      // colour low byte
        S_END      // drain last byte
    } state_t;

    state_t                             state;
    logic [$clog2(HOLD+1)-1:0]          hold_cnt;
    logic [$clog2(LCD_INIT_LEN+1)-1:0]  init_idx;
    logic [$clog2(DIV+1)-1:0]           div_cnt;
    logic [2:0]                         bit_cnt;
    logic [7:0]                         shift_q;
    logic                               sh_busy;
    logic                               bit_end;   // end of high half
    logic                               sh_done;   // last bit finishing
    logic                               sh_idle;   // free for a new byte
    logic                               load;
    logic [7:0]                         load_byte;
    logic                               load_dc;
    logic [7:0]                         lo_q;      // pending low byte
    logic                               eof_q;
    logic                               first_q;   // ramwr just went out

    assign bit_end     = sh_busy && (div_cnt == $bits(div_cnt)'(DIV - 1)) && spi_clk;
    assign sh_done     = bit_end && (bit_cnt == 3'd7);
    assign sh_idle     = !sh_busy || sh_done;
    assign pixel_ready = (state == S_HI) && sh_idle;

    // next byte to shift, back to back with the previous one
    always_comb
    begin
        load      = 1'b0;
        load_byte = 8'h00;
        load_dc   = 1'b0;
        case (state)
            S_INIT:
                if (sh_idle && init_idx != $bits(init_idx)'(LCD_INIT_LEN))
                begin
                    load      = 1'b1;
                    load_byte = lcd_init_bytes[init_idx].data;
                    load_dc   = lcd_init_bytes[init_idx].dc;
                end
            S_CMD:
            begin
                load      = sh_idle;
                load_byte = LCD_RAMWR;
            end
            S_HI:
            begin
                load      = sh_idle && pixel_valid;
                load_byte = pixel.color[15:8];
                load_dc   = 1'b1;
            end
            S_LO:
            begin
                load      = sh_idle;
                load_byte = lo_q;
                load_dc   = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= S_RESET;
            hold_cnt <= '0;
            init_idx <= '0;
            spi_resn <= 1'b0;   // panel held in reset
            spi_csn  <= 1'b1;
            first_q  <= 1'b0;
        end
        else
        begin
            case (state)
                S_RESET:
                    if (hold_cnt == $bits(hold_cnt)'(HOLD - 1))
                    begin
                        spi_resn <= 1'b1;
                        spi_csn  <= 1'b0;   // select for the whole init
                        state    <= S_INIT;
                    end
                    else
                        hold_cnt <= hold_cnt + 1'b1;
                S_INIT:
                    if (load)
                        init_idx <= init_idx + 1'b1;
                    else if (sh_idle && init_idx == $bits(init_idx)'(LCD_INIT_LEN))
                    begin
                        spi_csn <= 1'b1;
                        state   <= S_IDLE;
                    end
                S_IDLE:
                    if (pixel_valid)
                    begin
                        spi_csn <= 1'b0;    // one clock of csn setup
                        state   <= S_CMD;
                    end
                S_CMD:
                    if (load)
                    begin
                        first_q <= 1'b1;
                        state   <= S_HI;
                    end
                S_HI:
                    if (load)
                    begin
                        first_q <= 1'b0;
                        state   <= S_LO;
                    end
                S_LO:
                    if (load)
                        state <= eof_q ? S_END : S_HI;
                S_END:
                    if (sh_idle)
                    begin
                        spi_csn <= 1'b1;
                        state   <= S_IDLE;
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_HI && load)
        begin
            lo_q  <= pixel.color[7:0];
            eof_q <= pixel.eof;
        end
    end

    // mode 3 serialiser: fall and drive, rise and hold
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sh_busy  <= 1'b0;
            spi_clk  <= 1'b1;   // cpol 1 idle
            spi_mosi <= 1'b0;
            spi_dc   <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= 3'd0;
        end
        else if (load)
        begin
            sh_busy  <= 1'b1;
            spi_clk  <= 1'b0;
            spi_mosi <= load_byte[7];
            spi_dc   <= load_dc;
            div_cnt  <= '0;
            bit_cnt  <= 3'd0;
        end
        else if (sh_busy)
        begin
            if (div_cnt == $bits(div_cnt)'(DIV - 1))
            begin
                div_cnt <= '0;
                if (!spi_clk)
                    spi_clk <= 1'b1;            // panel samples here
                else if (sh_done)
                    sh_busy <= 1'b0;
                else
                begin
                    spi_clk  <= 1'b0;
                    spi_mosi <= shift_q[7];
                    bit_cnt  <= bit_cnt + 3'd1;
                end
            end
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
            shift_q <= {load_byte[6:0], 1'b0};
        else if (bit_end && !sh_done)
            shift_q <= {shift_q[6:0], 1'b0};
    end

    a_csn_clk: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(spi_clk) |-> !spi_csn);

    // the frame's first pixel follows ramwr and no other pixel does
    a_first_pixel: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_valid && pixel_ready |-> (pixel.sof == first_q));

endmodule

/* rtl/hex_pixel_render.sv */
`timescale 1ns/1ns
`include "hexlcd_settings.svh"

module hex_pixel_render (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     status_valid,
    input  hexlcd_pkg::status_word_t status,
    input  logic                     pixel_ready,
    output logic                     status_ready,
    output logic                     pixel_valid,
    output hexlcd_pkg::pixel_t       pixel
);
    import hexlcd_pkg::*;

    localparam int W    = `HEXLCD_WIDTH;
    localparam int H    = `HEXLCD_HEIGHT;
    localparam int GW   = `HEXLCD_GLYPH_W;
    localparam int GH   = `HEXLCD_GLYPH_H;
    localparam int COLS = `HEXLCD_COLS;

    status_word_t         snap;      // word frozen for one frame
    logic                 running;   // generating a frame
    logic [$clog2(W)-1:0] x;
    logic [$clog2(H)-1:0] y;
    logic [3:0]           digit;     // 0 top left
    logic [2:0]           gx;        // column inside glyph
    logic [2:0]           gy;        // row inside glyph
    logic [3:0]           nibble;
    logic [5:0]           font_row;
    pixel_t               gen_pix;
    logic                 push;
    logic                 pop;
    pixel_t               buf_q [2]; // output skid buffer
    logic                 wr_ptr;
    logic                 rd_ptr;
    logic [1:0]           count;

    // frame control and raster scan
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            status_ready <= 1'b0;
            running      <= 1'b0;
            x            <= '0;
            y            <= '0;
        end
        else if (!running && !status_ready)
            status_ready <= 1'b1;                  // one cycle request
        else if (status_ready && status_valid)
        begin
            status_ready <= 1'b0;
            running      <= 1'b1;
            x            <= '0;
            y            <= '0;
        end
        else if (push)
        begin
            if (x == W - 1)
            begin
                x <= '0;
                if (y == H - 1)
                    running <= 1'b0;               // frame done
                else
                    y <= y + 1'b1;
            end
            else
                x <= x + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (status_ready && status_valid)
            snap <= status;
    end

    assign digit    = 4'((y / GH) * COLS + x / GW);
    assign gx       = 3'(x % GW);
    assign gy       = 3'(y % GH);
    assign nibble   = snap[(4'd15 - digit) * 4 +: 4];   // msb nibble first
    assign font_row = hex_font[nibble][gy];

    always_comb
    begin
        gen_pix.color = font_row[3'(GW - 1) - gx] ? `HEXLCD_FG : `HEXLCD_BG;
        gen_pix.sof   = (x == 0) && (y == 0);
        gen_pix.eof   = (x == W - 1) && (y == H - 1);
    end

    // two entry buffer, generator stalls when full
    assign push        = running && (count != 2'd2);
    assign pop         = pixel_valid && pixel_ready;
    assign pixel_valid = (count != 2'd0);
    assign pixel       = buf_q[rd_ptr];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end
        else
        begin
            if (push)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
            count <= count + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            buf_q[wr_ptr] <= gen_pix;
    end

    a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel));

    a_scan_range: assert property (@(posedge clk) disable iff (!rst_n)
        (x < W) && (y < H));

endmodule

/* rtl/eink_bus_probe.sv */
`timescale 1ns/1ns

module eink_bus_probe (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     host_dc,
    input  logic                     host_sdi,
    input  logic                     host_cs,
    input  logic                     host_clk,
    input  logic                     panel_busy,
    input  logic                     status_ready,
    output logic                     panel_dc,
    output logic                     panel_sdi,
    output logic                     panel_cs,
    output logic                     panel_clk,
    output logic                     host_busy,
    output logic                     status_valid,
    output hexlcd_pkg::status_word_t status
);
    logic [4:0] sync1;      // {busy, dc, cs, sclk, sdi}
    logic [4:0] sync2;
    logic       sclk_d;     // for rising edge detect
    logic       sclk_rise;
    logic [2:0] bit_cnt;
    logic [7:0] shift_q;    // snooped byte msb first
    logic       byte_stb;   // full byte in shift_q

    // one flop relay from host to panel and busy back
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            panel_dc  <= 1'b0;
            panel_sdi <= 1'b0;
            panel_cs  <= 1'b1;   // deselected
            panel_clk <= 1'b0;
            host_busy <= 1'b0;
        end
        else
        begin
            panel_dc  <= host_dc;
            panel_sdi <= host_sdi;
            panel_cs  <= host_cs;
            panel_clk <= host_clk;
            host_busy <= panel_busy;
        end
    end

    // two flop synchroniser on the snoop side
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync1  <= 5'b00100;
            sync2  <= 5'b00100;
            sclk_d <= 1'b0;
        end
        else
        begin
            sync1  <= {panel_busy, host_dc, host_cs, host_clk, host_sdi};
            sync2  <= sync1;
            sclk_d <= sync2[1];
        end
    end

    assign sclk_rise = sync2[1] & ~sclk_d;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt  <= 3'd0;
            byte_stb <= 1'b0;
        end
        else
        begin
            byte_stb <= 1'b0;
            if (sync2[2])                     // cs high drops a partial byte
                bit_cnt <= 3'd0;
            else if (sclk_rise)
            begin
                bit_cnt  <= bit_cnt + 3'd1;   // wraps after bit 7
                byte_stb <= (bit_cnt == 3'd7);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!sync2[2] && sclk_rise)
            shift_q <= {shift_q[6:0], sync2[0]};
    end

    // status word tracks the live bus apart from the byte history
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            status       <= '0;
            status_valid <= 1'b0;
        end
        else
        begin
            status_valid <= 1'b1;   // always offering
            status.busy  <= sync2[4];
            status.dc    <= sync2[3];
            if (byte_stb)
            begin
                if (status.byte_count != '1)
                    status.byte_count <= status.byte_count + 14'd1;
                status.last_bytes <= {status.last_bytes[39:0], shift_q};
            end
        end
    end

    // count only grows between resets
    a_count_mono: assert property (@(posedge clk) disable iff (!rst_n)
        status.byte_count >= $past(status.byte_count));

endmodule

/* rtl/hexlcd_pkg.sv */
package hexlcd_pkg;

    // snapshot of the e-ink bus, digit 0 = top nibble
    typedef struct packed {
        logic        busy;
        logic        dc;
        logic [13:0] byte_count;  // saturating
        logic [47:0] last_bytes;  // newest byte in [7:0]
    } status_word_t;

    typedef struct packed {
        logic [15:0] color;  // rgb565
        logic        sof;    // first pixel of frame
        logic        eof;    // last pixel of frame
    } pixel_t;

    typedef struct packed {
        logic       dc;      // 0 command, 1 data
        logic [7:0] data;
    } lcd_byte_t;

    // 6x8 glyphs, leftmost pixel in bit 5, octal rows
    localparam logic [5:0] hex_font [16][8] = '{
        '{6'o34, 6'o42, 6'o46, 6'o52, 6'o62, 6'o42, 6'o34, 6'o00},  // 0
        '{6'o10, 6'o30, 6'o10, 6'o10, 6'o10, 6'o10, 6'o34, 6'o00},  // 1
        '{6'o34, 6'o42, 6'o02, 6'o04, 6'o10, 6'o20, 6'o76, 6'o00},  // 2
        '{6'o76, 6'o04, 6'o10, 6'o04, 6'o02, 6'o42, 6'o34, 6'o00},  // 3
        '{6'o04, 6'o14, 6'o24, 6'o44, 6'o76, 6'o04, 6'o04, 6'o00},  // 4
        '{6'o76, 6'o40, 6'o74, 6'o02, 6'o02, 6'o42, 6'o34, 6'o00},  // 5
        '{6'o14, 6'o20, 6'o40, 6'o74, 6'o42, 6'o42, 6'o34, 6'o00},  // 6
        '{6'o76, 6'o02, 6'o04, 6'o10, 6'o20, 6'o20, 6'o20, 6'o00},  // 7
        '{6'o34, 6'o42, 6'o42, 6'o34, 6'o42, 6'o42, 6'o34, 6'o00},  // 8
        '{6'o34, 6'o42, 6'o42, 6'o36, 6'o02, 6'o04, 6'o30, 6'o00},  // 9
        '{6'o34, 6'o42, 6'o42, 6'o76, 6'o42, 6'o42, 6'o42, 6'o00},  // a
        '{6'o74, 6'o42, 6'o42, 6'o74, 6'o42, 6'o42, 6'o74, 6'o00},  // b
        '{6'o34, 6'o42, 6'o40, 6'o40, 6'o40, 6'o42, 6'o34, 6'o00},  // c
        '{6'o70, 6'o44, 6'o42, 6'o42, 6'o42, 6'o44, 6'o70, 6'o00},  // d
        '{6'o76, 6'o40, 6'o40, 6'o74, 6'o40, 6'o40, 6'o76, 6'o00},  // e
        '{6'o76, 6'o40, 6'o40, 6'o74, 6'o40, 6'o40, 6'o40, 6'o00}   // f
    };

    localparam int LCD_INIT_LEN = 9;

    localparam lcd_byte_t lcd_init_bytes [LCD_INIT_LEN] = '{
        '{1'b0, 8'h01},  // swreset
        '{1'b0, 8'h11},  // sleep out
        '{1'b0, 8'h3A},  // colmod
        '{1'b1, 8'h55},  // 16 bit/pixel
        '{1'b0, 8'h21},  // inversion on
        '{1'b0, 8'h13},  // normal mode
        '{1'b0, 8'h29},  // display on
        '{1'b0, 8'h2A},  // caset, panel defaults kept
        '{1'b0, 8'h2B}   // raset, panel defaults kept
    };

    localparam logic [7:0] LCD_RAMWR = 8'h2C;

endpackage

/* rtl/hexlcd_settings.svh */
`ifndef HEXLCD_SETTINGS_SVH
`define HEXLCD_SETTINGS_SVH

// screen layout, two rows of eight hex digits
`define HEXLCD_COLS       8
`define HEXLCD_ROWS       2
`define HEXLCD_GLYPH_W    6    // glyph cell width in pixels
`define HEXLCD_GLYPH_H    8    // glyph cell height in pixels

`define HEXLCD_WIDTH      (`HEXLCD_COLS * `HEXLCD_GLYPH_W)
`define HEXLCD_HEIGHT     (`HEXLCD_ROWS * `HEXLCD_GLYPH_H)

// rgb565 colours
`define HEXLCD_FG         16'hFFE0   // yellow digits
`define HEXLCD_BG         16'h001F   // on blue

// spi timing
`define HEXLCD_SPI_DIV    2    // sys clocks per half spi period

// lcd reset pulse length after rst_n, in sys clocks
`define HEXLCD_RESET_HOLD 16

`endif
